// File: flist.f
sms_pkg.sv
sms_clk_enables.sv
sms_rom_loader.sv
sms_reset_ctrl.sv
sms_backup_seq.sv
sms_host_glue.sv
tb_sms_host_glue.sv

// File: Makefile
# Verilator build and run of the host glue testbench
VERILATOR ?= verilator
TOP       ?= tb_sms_host_glue
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_sms_host_glue.sv
// ============================================================
// self-checking testbench; ROM memory and SD host are modelled
// in tasks, all random stimulus comes from one fixed seed
// ============================================================
`default_nettype none

module tb_sms_host_glue;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int AW = sms_pkg::ROM_AW;
    localparam int NAW = sms_pkg::NV_AW;
    localparam int SAW = sms_pkg::SECTOR_AW;
    // roughly 46k cycles of tests plus margin
    localparam int TIMEOUT_CYCLES = 60000;

    logic              clk_sys = 1'b0;
    logic              rst_i;
    sms_pkg::ioctl_t   ioctl_i;
    logic              ioctl_download_i;
    logic              ioctl_wait_o;
    logic              rom_wr_req_o;
    logic [AW-1:0]     rom_waddr_o;
    logic [7:0]        rom_din_o;
    logic              rom_wr_ack_i;
    logic [AW-1:0]     rom_a_i;
    logic [AW-1:0]     rom_raddr_o;
    sms_pkg::ce_t      ce_o;
    logic              user_reset_i;
    logic              core_reset_o;
    logic              img_mounted_i;
    logic [31:0]       img_size_i;
    logic              bk_save_i;
    sms_pkg::sd_req_t  sd_req_o;
    logic              sd_ack_i;
    sms_pkg::sd_buff_t sd_buff_i;
    logic [7:0]        sd_buff_din_o;
    sms_pkg::nv_port_t nv_i;
    logic [7:0]        nv_q_o;
    logic              led_o;

    integer     seed = 32'ha40f_c8ac;
    int         cycle_cnt = 0;
    logic       ce_armed = 1'b0;
    int         ce_start;
    int         arm_cycle;
    // expected backup RAM contents
    logic [7:0] exp_mem [2**NAW];

    sms_host_glue u_dut (.*);

    always #20 clk_sys = ~clk_sys;

    // ========================================================
    // reference model
    // ========================================================
    // strobe set that follows phase count p
    function automatic sms_pkg::ce_t exp_ce(input int p);
        sms_pkg::ce_t c;
        c.vdp   = (p % 5) == 4;
        c.pix   = (p % 10) == 9;
        c.cpu_p = (p == 9) || (p == 24);
        c.cpu_n = (p == 2) || (p == 17);
        c.sp    = (p % 2) == 1;
        return c;
    endfunction

    function automatic logic [AW-1:0] exp_raddr(input logic [AW-1:0] a,
                                                 input logic [AW-1:0] mask,
                                                 input logic hdr);
        logic [AW-1:0] ofs;
        ofs = hdr ? AW'(sms_pkg::HDR_OFFSET) : '0;
        return (a & mask) + ofs;
    endfunction

    // load image byte built from all address bits
    function automatic logic [7:0] save_pattern(input int addr);
        logic [NAW-1:0] a;
        a = NAW'(addr);
        return a[7:0] ^ {3'b101, a[12:8]};
    endfunction

    // ========================================================
    // compare tasks
    // ========================================================
    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_ce(input sms_pkg::ce_t got, input sms_pkg::ce_t exp, input string msg);
        if (got !== exp) report_mismatch($sformatf("%s: got %b exp %b", msg, got, exp));
    endtask

    task automatic check_addr(input logic [AW-1:0] got, input logic [AW-1:0] exp,
                              input string msg);
        if (got !== exp) report_mismatch($sformatf("%s: got %h exp %h", msg, got, exp));
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
        if (got !== exp) report_mismatch($sformatf("%s: got %h exp %h", msg, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) report_mismatch($sformatf("%s: got %b exp %b", msg, got, exp));
    endtask

    // ========================================================
    // timeout and strobe monitor
    // ========================================================
    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // phase follows from cycles since the first cpu_p
    always @(posedge clk_sys) begin
        if (ce_armed) begin
            #1;
            check_ce(ce_o, exp_ce((ce_start + cycle_cnt - arm_cycle) % sms_pkg::CE_PERIOD),
                     "strobe pattern");
        end
    end

    // ========================================================
    // stimulus tasks
    // ========================================================
    // inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    // host download with random acknowledge delay
    task automatic download(input int nbytes);
        logic [7:0] d;
        logic       req_before;
        int         delay;
        ioctl_download_i = 1'b1;
        next_cycle();
        next_cycle();
        for (int i = 0; i < nbytes; i++) begin
            d = 8'($random(seed));
            req_before = rom_wr_req_o;
            ioctl_i = {1'b1, AW'(i), d};
            next_cycle();
            ioctl_i.wr = 1'b0;
            check_bit(core_reset_o, 1'b1, "core reset during download");
            check_bit(rom_wr_req_o, ~req_before, "request toggles on write");
            check_addr(rom_waddr_o, AW'(i), "write address");
            check_byte(rom_din_o, d, "write data");
            delay = $random(seed) & 3;
            repeat (delay) begin
                check_bit(ioctl_wait_o, 1'b1, "wait held until ack");
                next_cycle();
            end
            check_bit(ioctl_wait_o, 1'b1, "wait held until ack");
            check_bit(rom_wr_req_o, ~req_before, "one toggle per write");
            rom_wr_ack_i = rom_wr_req_o;
            next_cycle();
            while (ioctl_wait_o) next_cycle();
            // wait seen low for one cycle
            next_cycle();
        end
    endtask

    task automatic check_rom_reads(input logic [AW-1:0] mask, input logic hdr);
        logic [AW-1:0] a;
        repeat (20) begin
            a = AW'($random(seed));
            rom_a_i = a;
            next_cycle();
            check_addr(rom_raddr_o, exp_raddr(a, mask, hdr), "translated ROM address");
        end
    endtask

    // SD host model serving all 16 sectors
    // load fills the RAM from exp_mem and save compares against it
    task automatic serve_sectors(input logic load);
        int delay;
        int base;
        for (int s = 0; s < sms_pkg::SECTORS; s++) begin
            while (!(sd_req_o.rd || sd_req_o.wr)) next_cycle();
            check_byte(8'(sd_req_o.lba), 8'(s), "sector lba");
            check_bit(sd_req_o.rd, load, "read request");
            check_bit(sd_req_o.wr, ~load, "write request");
            delay = $random(seed) & 3;
            repeat (delay) next_cycle();
            sd_ack_i = 1'b1;
            next_cycle();
            check_bit(sd_req_o.rd | sd_req_o.wr, 1'b0, "request clears after ack");
            base = s * 512;
            for (int b = 0; b < 512; b++) begin
                sd_buff_i = {SAW'(b), load ? exp_mem[base + b] : 8'h00, load};
                next_cycle();
                if (!load) check_byte(sd_buff_din_o, exp_mem[base + b], "saved byte");
            end
            sd_buff_i.wr = 1'b0;
            sd_ack_i = 1'b0;
            next_cycle();
        end
    endtask

    // ========================================================
    // test sequence
    // ========================================================
    initial begin
        int         n;
        int         addr;
        int         cnt_vdp;
        int         cnt_pix;
        int         cnt_cpu_p;
        int         cnt_cpu_n;
        int         cnt_sp;
        logic       seen;
        logic [7:0] d;
        rst_i = 1'b1;
        ioctl_i = '0;
        ioctl_download_i = 1'b0;
        rom_wr_ack_i = 1'b0;
        rom_a_i = '0;
        user_reset_i = 1'b0;
        img_mounted_i = 1'b0;
        img_size_i = 32'd0;
        bk_save_i = 1'b0;
        sd_ack_i = 1'b0;
        sd_buff_i = '0;
        nv_i = '0;
        repeat (16) @(posedge clk_sys);
        #2;
        check_ce(ce_o, '0, "strobes in reset");
        check_bit(ioctl_wait_o, 1'b0, "wait in reset");
        check_bit(rom_wr_req_o, 1'b0, "request in reset");
        check_bit(sd_req_o.rd | sd_req_o.wr, 1'b0, "sd request in reset");
        check_bit(core_reset_o, 1'b1, "core reset in reset");
        check_bit(led_o, 1'b1, "led in reset");
        rst_i = 1'b0;

        // strobe counts over two full patterns
        while (!ce_o.cpu_p) next_cycle();
        ce_start = ce_o.pix ? 9 : 24;
        arm_cycle = cycle_cnt;
        ce_armed = 1'b1;
        for (int w = 0; w < 2; w++) begin
            cnt_vdp = 0;
            cnt_pix = 0;
            cnt_cpu_p = 0;
            cnt_cpu_n = 0;
            cnt_sp = 0;
            for (int c = 0; c < sms_pkg::CE_PERIOD; c++) begin
                next_cycle();
                cnt_vdp += int'(ce_o.vdp);
                cnt_pix += int'(ce_o.pix);
                cnt_cpu_p += int'(ce_o.cpu_p);
                cnt_cpu_n += int'(ce_o.cpu_n);
                cnt_sp += int'(ce_o.sp);
            end
            check_byte(8'(cnt_vdp), 8'd6, "vdp strobes per pattern");
            check_byte(8'(cnt_pix), 8'd3, "pix strobes per pattern");
            check_byte(8'(cnt_cpu_p), 8'd2, "cpu_p strobes per pattern");
            check_byte(8'(cnt_cpu_n), 8'd2, "cpu_n strobes per pattern");
            check_byte(8'(cnt_sp), 8'd15, "sp strobes per pattern");
        end

        // headered image with mask 0x7ff
        download(1536);
        ioctl_download_i = 1'b0;
        n = 0;
        while (core_reset_o) begin
            next_cycle();
            n++;
        end
        check_bit((n >= sms_pkg::RESET_HOLD_TICKS * 15) &&
                  (n <= sms_pkg::RESET_HOLD_TICKS * 15 + 40), 1'b1,
                  $sformatf("reset released after %0d cycles", n));
        check_rom_reads(AW'(12'h7FF), 1'b1);
        user_reset_i = 1'b1;
        next_cycle();
        check_bit(core_reset_o, 1'b1, "user reset");
        user_reset_i = 1'b0;
        next_cycle();
        check_bit(core_reset_o, 1'b0, "release after user reset");

        // mount and load the save image
        for (int i = 0; i < 2**NAW; i++) exp_mem[i] = save_pattern(i);
        img_size_i = 32'h2000;
        img_mounted_i = 1'b1;
        next_cycle();
        img_mounted_i = 1'b0;
        serve_sectors(1'b1);
        seen = 1'b0;
        repeat (4) begin
            next_cycle();
            seen |= core_reset_o;
        end
        check_bit(seen, 1'b1, "core reset pulse after load");
        check_bit(core_reset_o, 1'b0, "core reset pulse ends");
        check_bit(led_o, 1'b0, "led while backup enabled");
        repeat (128) begin
            addr = $random(seed) & 32'h1FFF;
            nv_i = {NAW'(addr), 8'h00, 1'b0};
            next_cycle();
            check_byte(nv_q_o, exp_mem[addr], "core read of loaded save");
        end

        // core updates then a save back to SD
        repeat (256) begin
            addr = $random(seed) & 32'h1FFF;
            d = 8'($random(seed));
            nv_i = {NAW'(addr), d, 1'b1};
            exp_mem[addr] = d;
            next_cycle();
        end
        nv_i.we = 1'b0;
        bk_save_i = 1'b1;
        next_cycle();
        bk_save_i = 1'b0;
        serve_sectors(1'b0);

        // new cart drops backup
        // plain image with mask 0x3ff
        download(1024);
        ioctl_download_i = 1'b0;
        next_cycle();
        check_bit(led_o, 1'b1, "led after new download");
        check_rom_reads(AW'(12'h3FF), 1'b0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sms_host_glue.sv
// ============================================================
// single clock domain; led_o is active high, lit when idle
// ============================================================
`default_nettype none

module sms_host_glue (
    input  wire                        clk_sys,
    input  wire                        rst_i,
    // download from the host
    input  wire sms_pkg::ioctl_t       ioctl_i,
    input  wire                        ioctl_download_i,
    output logic                       ioctl_wait_o,
    // external ROM memory
    output logic                       rom_wr_req_o,
    output logic [sms_pkg::ROM_AW-1:0] rom_waddr_o,
    output logic [7:0]                 rom_din_o,
    input  wire                        rom_wr_ack_i,
    input  wire  [sms_pkg::ROM_AW-1:0] rom_a_i,
    output logic [sms_pkg::ROM_AW-1:0] rom_raddr_o,
    // core timing and reset
    output sms_pkg::ce_t               ce_o,
    input  wire                        user_reset_i,
    output logic                       core_reset_o,
    // SD backup
    input  wire                        img_mounted_i,
    input  wire  [31:0]                img_size_i,
    input  wire                        bk_save_i,
    output sms_pkg::sd_req_t           sd_req_o,
    input  wire                        sd_ack_i,
    input  wire sms_pkg::sd_buff_t     sd_buff_i,
    output logic [7:0]                 sd_buff_din_o,
    // core side of backup RAM
    input  wire sms_pkg::nv_port_t     nv_i,
    output logic [7:0]                 nv_q_o,
    output logic                       led_o
);

    logic bk_ena;
    logic bk_reset;

    // ========================================================
    // instances
    // ========================================================
    sms_clk_enables u_ce (
        .clk_sys (clk_sys),
        .rst_i   (rst_i),
        .ce_o    (ce_o)
    );

    sms_rom_loader u_rom (
        .clk_sys          (clk_sys),
        .rst_i            (rst_i),
        .ioctl_i          (ioctl_i),
        .ioctl_download_i (ioctl_download_i),
        .ioctl_wait_o     (ioctl_wait_o),
        .rom_wr_req_o     (rom_wr_req_o),
        .rom_waddr_o      (rom_waddr_o),
        .rom_din_o        (rom_din_o),
        .rom_wr_ack_i     (rom_wr_ack_i),
        .rom_a_i          (rom_a_i),
        .rom_raddr_o      (rom_raddr_o)
    );

    // hold count runs on cpu_p
    sms_reset_ctrl u_rst (
        .clk_sys          (clk_sys),
        .rst_i            (rst_i),
        .ce_i             (ce_o),
        .ioctl_download_i (ioctl_download_i),
        .user_reset_i     (user_reset_i),
        .bk_reset_i       (bk_reset),
        .core_reset_o     (core_reset_o)
    );

    sms_backup_seq u_bk (
        .clk_sys          (clk_sys),
        .rst_i            (rst_i),
        .ioctl_download_i (ioctl_download_i),
        .img_mounted_i    (img_mounted_i),
        .img_size_i       (img_size_i),
        .bk_save_i        (bk_save_i),
        .sd_req_o         (sd_req_o),
        .sd_ack_i         (sd_ack_i),
        .sd_buff_i        (sd_buff_i),
        .sd_buff_din_o    (sd_buff_din_o),
        .nv_i             (nv_i),
        .nv_q_o           (nv_q_o),
        .bk_ena_o         (bk_ena),
        .bk_reset_o       (bk_reset)
    );

    // dark while loading or while a save is mounted
    assign led_o = ~ioctl_download_i & ~bk_ena;

endmodule

`default_nettype wire

// File: sms_backup_seq.sv
// ============================================================
// SD host paces each sector; a mount during a save is not
// queued, it only flips the transfer direction
// ============================================================
`default_nettype none

module sms_backup_seq (
    input  wire                    clk_sys,
    input  wire                    rst_i,
    input  wire                    ioctl_download_i,
    input  wire                    img_mounted_i,
    input  wire  [31:0]            img_size_i,
    input  wire                    bk_save_i,
    output sms_pkg::sd_req_t       sd_req_o,
    input  wire                    sd_ack_i,
    input  wire sms_pkg::sd_buff_t sd_buff_i,
    output logic [7:0]             sd_buff_din_o,
    input  wire sms_pkg::nv_port_t nv_i,
    output logic [7:0]             nv_q_o,
    output logic                   bk_ena_o,
    output logic                   bk_reset_o
);

    // ========================================================
    // backup RAM with core on port a and sd buffer on port b
    // ========================================================
    logic [7:0]                nv_mem [2**sms_pkg::NV_AW];
    logic [sms_pkg::NV_AW-1:0] sd_ram_addr;
    logic                      sd_ram_we;

    // sector index picks the 512 byte page
    assign sd_ram_addr = {sd_req_o.lba, sd_buff_i.addr};
    // stray buffer writes outside a transfer are dropped
    assign sd_ram_we = sd_buff_i.wr & sd_ack_i;

    always_ff @(posedge clk_sys) begin
        if (nv_i.we) begin
            nv_mem[nv_i.addr] <= nv_i.data;
        end
        if (sd_ram_we) begin
            nv_mem[sd_ram_addr] <= sd_buff_i.data;
        end
        nv_q_o        <= nv_mem[nv_i.addr];
        sd_buff_din_o <= nv_mem[sd_ram_addr];
    end

    // ========================================================
    // sector sequencer
    // ========================================================
    sms_pkg::bk_state_e state_q;
    logic bk_load_q;
    logic load_q;
    logic save_q;
    logic ack_q;
    logic mount_q;
    logic dl_q;

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            state_q    <= sms_pkg::BK_IDLE;
            sd_req_o   <= '0;
            bk_ena_o   <= 1'b0;
            bk_load_q  <= 1'b0;
            bk_reset_o <= 1'b0;
            load_q     <= 1'b0;
            save_q     <= 1'b0;
            ack_q      <= 1'b0;
            mount_q    <= 1'b0;
            dl_q       <= 1'b0;
        end else begin
            bk_reset_o <= 1'b0;
            dl_q       <= ioctl_download_i;
            mount_q    <= img_mounted_i;
            load_q     <= bk_load_q;
            save_q     <= bk_save_i;
            ack_q      <= sd_ack_i;
            // a new cart invalidates the mounted save
            if (ioctl_download_i && !dl_q) begin
                bk_ena_o <= 1'b0;
            end
            if (img_mounted_i && !mount_q && (img_size_i != 32'd0)) begin
                bk_ena_o  <= 1'b1;
                bk_load_q <= 1'b1;
            end
            // host took the request
            if (sd_ack_i && !ack_q) begin
                sd_req_o.rd <= 1'b0;
                sd_req_o.wr <= 1'b0;
            end
            case (state_q)
                sms_pkg::BK_IDLE: begin
                    if (bk_ena_o && ((bk_load_q && !load_q) || (bk_save_i && !save_q))) begin
                        state_q      <= sms_pkg::BK_XFER;
                        sd_req_o.lba <= '0;
                        sd_req_o.rd  <= bk_load_q;
                        sd_req_o.wr  <= ~bk_load_q;
                    end
                end
                sms_pkg::BK_XFER: begin
                    // sector done when ack drops
                    if (!sd_ack_i && ack_q) begin
                        if (int'(sd_req_o.lba) == sms_pkg::SECTORS - 1) begin
                            // restart the core on the loaded save
                            bk_reset_o <= bk_load_q;
                            bk_load_q  <= 1'b0;
                            state_q    <= sms_pkg::BK_IDLE;
                        end else begin
                            sd_req_o.lba <= sd_req_o.lba + 1'b1;
                            sd_req_o.rd  <= bk_load_q;
                            sd_req_o.wr  <= ~bk_load_q;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sms_reset_ctrl.sv
// ============================================================
// power-up also runs the full hold; output is registered
// ============================================================
`default_nettype none

module sms_reset_ctrl (
    input  wire          clk_sys,
    input  wire          rst_i,
    input  wire sms_pkg::ce_t ce_i,
    input  wire          ioctl_download_i,
    input  wire          user_reset_i,
    input  wire          bk_reset_i,
    output logic         core_reset_o
);

    logic [$clog2(sms_pkg::RESET_HOLD_TICKS + 1)-1:0] hold_cnt_q;
    logic                                             hold_q;

    // some carts need the longer start after a load
    always_ff @(posedge clk_sys) begin
        if (rst_i || ioctl_download_i) begin
            hold_cnt_q <= sms_pkg::RESET_HOLD_TICKS[$bits(hold_cnt_q)-1:0];
            hold_q     <= 1'b1;
        end else if (ce_i.cpu_p) begin
            if (hold_cnt_q != '0) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
            end else begin
                // released on the tick after the count runs out
                hold_q <= 1'b0;
            end
        end
    end

    // merge all causes
    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            core_reset_o <= 1'b1;
        end else begin
            core_reset_o <= user_reset_i | ioctl_download_i | hold_q | bk_reset_i;
        end
    end

endmodule

`default_nettype wire

// File: sms_rom_loader.sv
// ============================================================
// one download byte in flight; host waits on ioctl_wait_o
// ============================================================
`default_nettype none

module sms_rom_loader (
    input  wire                        clk_sys,
    input  wire                        rst_i,
    input  wire sms_pkg::ioctl_t       ioctl_i,
    input  wire                        ioctl_download_i,
    output logic                       ioctl_wait_o,
    output logic                       rom_wr_req_o,
    output logic [sms_pkg::ROM_AW-1:0] rom_waddr_o,
    output logic [7:0]                 rom_din_o,
    input  wire                        rom_wr_ack_i,
    input  wire  [sms_pkg::ROM_AW-1:0] rom_a_i,
    output logic [sms_pkg::ROM_AW-1:0] rom_raddr_o
);

    logic                       dl_q;
    logic [sms_pkg::ROM_AW-1:0] cart_mask_q;
    logic                       romhdr_q;
    logic [sms_pkg::ROM_AW-1:0] hdr_add;

    // ========================================================
    // download write side
    // ========================================================
    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            dl_q         <= 1'b0;
            ioctl_wait_o <= 1'b0;
            rom_wr_req_o <= 1'b0;
            cart_mask_q  <= '0;
            romhdr_q     <= 1'b0;
        end else begin
            dl_q <= ioctl_download_i;
            if (ioctl_download_i && !dl_q) begin
                // new image, forget the old size
                cart_mask_q  <= '0;
                romhdr_q     <= 1'b0;
                ioctl_wait_o <= 1'b0;
            end else if (ioctl_i.wr) begin
                ioctl_wait_o <= 1'b1;
                // toggle marks a new request
                rom_wr_req_o <= ~rom_wr_req_o;
                // mask grows to cover the highest address bit
                cart_mask_q  <= cart_mask_q | ioctl_i.addr;
                romhdr_q     <= (ioctl_i.addr[9:0] == sms_pkg::HDR_MARK);
            end else if (ioctl_wait_o && (rom_wr_req_o == rom_wr_ack_i)) begin
                ioctl_wait_o <= 1'b0;
            end
        end
    end

    // address and data held while the request is pending
    always_ff @(posedge clk_sys) begin
        if (ioctl_i.wr) begin
            rom_waddr_o <= ioctl_i.addr;
            rom_din_o   <= ioctl_i.data;
        end
    end

    // ========================================================
    // cpu read side
    // ========================================================
    // skip the copier header when present
    assign hdr_add = romhdr_q ? sms_pkg::HDR_OFFSET[sms_pkg::ROM_AW-1:0] : '0;

    // mirror small carts across the window
    always_ff @(posedge clk_sys) begin
        rom_raddr_o <= (rom_a_i & cart_mask_q) + hdr_add;
    end

endmodule

`default_nettype wire

// File: sms_clk_enables.sv
// ============================================================
// strobes lag the phase count by one cycle; all low in reset
// ============================================================
`default_nettype none

module sms_clk_enables (
    input  wire          clk_sys,
    input  wire          rst_i,
    output sms_pkg::ce_t ce_o
);

    // phase of the 30-cycle pattern
    logic [$clog2(sms_pkg::CE_PERIOD)-1:0] phase_q;

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            phase_q <= '0;
        end else if (int'(phase_q) == sms_pkg::CE_PERIOD - 1) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // ========================================================
    // strobe decode
    // ========================================================
    // vdp every 5, pix every 10, cpu every 15 cycles
    // cpu_n sits midway between the cpu_p ticks
    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            ce_o <= '0;
        end else begin
            // sprite strobe runs at half clk_sys
            ce_o.sp    <= phase_q[0];
            ce_o.vdp   <= 1'b0;
            ce_o.pix   <= 1'b0;
            ce_o.cpu_p <= 1'b0;
            ce_o.cpu_n <= 1'b0;
            case (int'(phase_q))
                2, 17: begin
                    ce_o.cpu_n <= 1'b1;
                end
                4, 14: begin
                    ce_o.vdp <= 1'b1;
                end
                9: begin
                    ce_o.vdp   <= 1'b1;
                    ce_o.pix   <= 1'b1;
                    ce_o.cpu_p <= 1'b1;
                end
                19, 29: begin
                    ce_o.vdp <= 1'b1;
                    ce_o.pix <= 1'b1;
                end
                24: begin
                    ce_o.vdp   <= 1'b1;
                    ce_o.cpu_p <= 1'b1;
                end
                default: begin
                    // no strobe on this phase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sms_pkg.sv
// ============================================================
// shared widths and bus types of the host glue; ROM window is
// fixed at 4 MB and backup RAM at 8 KB (16 sectors of 512)
// ============================================================
`default_nettype none

package sms_pkg;

    // ========================================================
    // timing
    // ========================================================
    // clk_sys cycles in one enable pattern
    localparam int CE_PERIOD = 30;
    // cpu ticks of reset after a download ends
    localparam int RESET_HOLD_TICKS = 1000;

    // ========================================================
    // cartridge ROM
    // ========================================================
    localparam int ROM_AW = 22;
    // bytes skipped when the image carries a copier header
    localparam int HDR_OFFSET = 512;
    // headered images end on an address with low bits 0x1ff
    localparam logic [9:0] HDR_MARK = 10'h1FF;

    // ========================================================
    // battery backup
    // ========================================================
    localparam int NV_AW = 13;
    localparam int SECTORS = 16;
    localparam int SECTOR_AW = 9;

    // clock enable strobes, one clk_sys cycle wide
    typedef struct packed {
        logic cpu_p;
        logic cpu_n;
        logic vdp;
        logic pix;
        logic sp;
    } ce_t;

    // download byte stream from the host
    typedef struct packed {
        logic              wr;
        logic [ROM_AW-1:0] addr;
        logic [7:0]        data;
    } ioctl_t;

    // sector request to the SD host
    typedef struct packed {
        logic                       rd;
        logic                       wr;
        logic [$clog2(SECTORS)-1:0] lba;
    } sd_req_t;

    // SD sector buffer side, byte address inside the sector
    typedef struct packed {
        logic [SECTOR_AW-1:0] addr;
        logic [7:0]           data;
        logic                 wr;
    } sd_buff_t;

    // core side of the backup RAM
    typedef struct packed {
        logic [NV_AW-1:0] addr;
        logic [7:0]       data;
        logic             we;
    } nv_port_t;

    typedef enum logic [0:0] {
        BK_IDLE,
        BK_XFER
    } bk_state_e;

endpackage

`default_nettype wire
